/* verilog/peakThreshPkg.sv */
`default_nettype none

package peakThreshPkg;

    // AXI4-Lite bus sizing
    localparam int AXI_ADDR_W = 8;
    localparam int AXI_DATA_W = 32;

    // register map, byte offsets
    typedef enum logic [AXI_ADDR_W-1:0] {
        REG_CTRL    = 8'h00,  // wo: bit0 clear, bit1 start
        REG_PIXEL   = 8'h04,  // wo: one pixel per write
        REG_STATUS  = 8'h08,  // ro: bit0 busy, bit1 done
        REG_RESULT  = 8'h0C,  // ro: thMinus, thPlus, peakBin
        REG_PEAKCNT = 8'h10   // ro: count of the peak bin
    } regAddrE;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10
    } axiRespE;

    // peak scan sequencing
    typedef enum logic [1:0] {
        S_IDLE,
        S_SCAN,
        S_FINISH
    } searchStateE;

endpackage

`default_nettype wire

/* verilog/axiLiteRegs.sv */
`default_nettype none

module axiLiteRegs #(
    parameter int pixelWidth = 8,
    parameter int binWidth   = 4,
    parameter int countWidth = 16
) (
    input  logic                                  clk,
    input  logic                                  res,
    // write address and data
    input  logic                                  awvalid,
    output logic                                  awready,
    input  logic [peakThreshPkg::AXI_ADDR_W-1:0]  awaddr,
    input  logic                                  wvalid,
    output logic                                  wready,
    input  logic [peakThreshPkg::AXI_DATA_W-1:0]  wdata,
    // write response
    output logic                                  bvalid,
    input  logic                                  bready,
    output logic [1:0]                            bresp,
    // read
    input  logic                                  arvalid,
    output logic                                  arready,
    input  logic [peakThreshPkg::AXI_ADDR_W-1:0]  araddr,
    output logic                                  rvalid,
    input  logic                                  rready,
    output logic [peakThreshPkg::AXI_DATA_W-1:0]  rdata,
    output logic [1:0]                            rresp,
    // status and results
    input  logic                                  busy,
    input  logic                                  resultValid,
    input  logic [pixelWidth-1:0]                 thMinus,
    input  logic [pixelWidth-1:0]                 thPlus,
    input  logic [binWidth-1:0]                   peakBin,
    input  logic [countWidth-1:0]                 peakCount,
    // control pulses
    output logic                                  pixWrite,
    output logic [pixelWidth-1:0]                 pixData,
    output logic                                  histClear,
    output logic                                  searchStart
);
    import peakThreshPkg::*;

    logic                  wrAccept;
    logic                  wrFire;
    logic                  wrBlocked;
    logic                  wrMapped;
    logic                  rdFire;
    logic                  rdMapped;
    logic [AXI_DATA_W-1:0] rdMux;

    // pixel and ctrl writes wait while a scan runs
    assign wrBlocked = busy && (awaddr == REG_PIXEL || awaddr == REG_CTRL);
    assign wrAccept  = awvalid && wvalid && !awready && !bvalid && !wrBlocked;
    assign wrFire    = awready && awvalid && wvalid;
    assign wready    = awready;  // address and data always taken together

    assign arready = !rvalid;
    assign rdFire  = arvalid && arready;

    always_comb begin
        wrMapped = 1'b1;
        case (awaddr)
            REG_CTRL, REG_PIXEL, REG_STATUS, REG_RESULT, REG_PEAKCNT: wrMapped = 1'b1;
            default: wrMapped = 1'b0;
        endcase
    end

    // read data assembly
    always_comb begin
        rdMux    = '0;
        rdMapped = 1'b1;
        case (araddr)
            REG_CTRL, REG_PIXEL: rdMux = '0;  // write only
            REG_STATUS: begin
                rdMux[0] = busy;
                rdMux[1] = resultValid;
            end
            REG_RESULT: begin
                rdMux[pixelWidth-1:0]   = thMinus;
                rdMux[8 +: pixelWidth]  = thPlus;
                rdMux[16 +: binWidth]   = peakBin;
            end
            REG_PEAKCNT: rdMux[countWidth-1:0] = peakCount;
            default: rdMapped = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            awready     <= 1'b0;
            bvalid      <= 1'b0;
            rvalid      <= 1'b0;
            pixWrite    <= 1'b0;
            histClear   <= 1'b0;
            searchStart <= 1'b0;
        end else begin
            awready     <= wrAccept;
            pixWrite    <= wrFire && awaddr == REG_PIXEL;
            histClear   <= wrFire && awaddr == REG_CTRL && wdata[0];
            searchStart <= wrFire && awaddr == REG_CTRL && wdata[1];
            if (wrFire) begin
                bvalid <= 1'b1;
            end else if (bready) begin
                bvalid <= 1'b0;
            end
            if (rdFire) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // payload, qualified by the valids above
    always_ff @(posedge clk) begin
        if (wrFire) begin
            pixData <= wdata[pixelWidth-1:0];
            bresp   <= wrMapped ? RESP_OKAY : RESP_SLVERR;
        end
        if (rdFire) begin
            rdata <= rdMux;
            rresp <= rdMapped ? RESP_OKAY : RESP_SLVERR;
        end
    end

endmodule

`default_nettype wire

/* verilog/histogramAccum.sv */
`default_nettype none

module histogramAccum #(
    parameter int pixelWidth = 8,
    parameter int binWidth   = 4,
    parameter int countWidth = 16
) (
    input  logic                  clk,
    input  logic                  res,
    input  logic                  pixWrite,
    input  logic [pixelWidth-1:0] pixData,
    input  logic                  histClear,
    input  logic [binWidth-1:0]   binSel,
    output logic [countWidth-1:0] binCount
);

    localparam int binNum = 2 ** binWidth;

    logic [countWidth-1:0] counts [binNum];
    logic                  incValid;  // increment pending
    logic [binWidth-1:0]   incBin;
    logic [countWidth-1:0] incCur;

    // bin = top bits of the pixel
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            incValid <= 1'b0;
        end else begin
            incValid <= pixWrite;
        end
    end

    always_ff @(posedge clk) begin
        if (pixWrite) begin
            incBin <= pixData[pixelWidth-1 -: binWidth];
        end
    end

    assign incCur = counts[incBin];

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            for (int i = 0; i < binNum; i++) begin
                counts[i] <= '0;
            end
        end else if (histClear) begin
            // clear beats a pending increment
            for (int i = 0; i < binNum; i++) begin
                counts[i] <= '0;
            end
        end else if (incValid && incCur != '1) begin
            counts[incBin] <= incCur + 1'b1;  // saturates at all ones
        end
    end

    // scan read port
    assign binCount = counts[binSel];

endmodule

`default_nettype wire

/* verilog/peakSearch.sv */
`default_nettype none

module peakSearch #(
    parameter int binWidth   = 4,
    parameter int countWidth = 16
) (
    input  logic                  clk,
    input  logic                  res,
    input  logic                  searchStart,
    input  logic [countWidth-1:0] binCount,
    output logic [binWidth-1:0]   binSel,
    output logic                  busy,
    output logic                  peakValid,
    output logic [binWidth-1:0]   peakBin,
    output logic [countWidth-1:0] peakCount
);
    import peakThreshPkg::*;

    searchStateE state;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state     <= S_IDLE;
            binSel    <= '0;
            peakBin   <= '0;
            peakCount <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    if (searchStart) begin
                        state     <= S_SCAN;
                        binSel    <= '0;
                        peakBin   <= '0;  // empty histogram ends at bin 0
                        peakCount <= '0;
                    end
                end
                S_SCAN: begin
                    // strict compare keeps the lower index on ties
                    if (binCount > peakCount) begin
                        peakCount <= binCount;
                        peakBin   <= binSel;
                    end
                    if (binSel == '1) begin
                        state <= S_FINISH;
                    end else begin
                        binSel <= binSel + 1'b1;
                    end
                end
                S_FINISH: state <= S_IDLE;
                default:  state <= S_IDLE;
            endcase
        end
    end

    assign busy      = state != S_IDLE;
    assign peakValid = state == S_FINISH;  // one cycle, result stable

endmodule

`default_nettype wire

/* verilog/thresholdCalc.sv */
`default_nettype none

module thresholdCalc #(
    parameter int pixelWidth = 8,
    parameter int binWidth   = 4,
    parameter int countWidth = 16
) (
    input  logic                  clk,
    input  logic                  res,
    input  logic                  searchStart,
    input  logic                  peakValid,
    input  logic [binWidth-1:0]   peakBin,
    input  logic [countWidth-1:0] peakCount,
    output logic [pixelWidth-1:0] thMinus,
    output logic [pixelWidth-1:0] thPlus,
    output logic [countWidth-1:0] peakCountOut,
    output logic                  resultValid
);

    localparam int binShift = pixelWidth - binWidth;
    // half window width
    localparam logic [pixelWidth-1:0] sbVal =
        pixelWidth'(2 ** (binWidth - 1) + 2 ** (binWidth - 2));
    localparam logic [pixelWidth-1:0] sbTwice = pixelWidth'(2 * sbVal);
    localparam logic [pixelWidth-1:0] pixMax  = '1;
    localparam logic [pixelWidth-1:0] binHalf = pixelWidth'(2 ** (binShift - 1));

    logic [pixelWidth-1:0] center;
    logic [pixelWidth-1:0] lowNext;
    logic [pixelWidth-1:0] highNext;

    assign center = (pixelWidth'(peakBin) << binShift) + binHalf;  // middle of peak bin

    always_comb begin
        if (center <= sbVal) begin
            lowNext  = '0;
            highNext = sbTwice;
        end else if (center >= pixMax - sbVal) begin
            lowNext  = pixMax - sbTwice;
            highNext = pixMax;
        end else begin
            lowNext  = center - sbVal;
            highNext = center + sbVal;
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            thMinus      <= '0;
            thPlus       <= '0;
            peakCountOut <= '0;
            resultValid  <= 1'b0;
        end else if (peakValid) begin
            thMinus      <= lowNext;
            thPlus       <= highNext;
            peakCountOut <= peakCount;
            resultValid  <= 1'b1;
        end else if (searchStart) begin
            resultValid <= 1'b0;  // stale until the new scan ends
        end
    end

endmodule

`default_nettype wire

/* verilog/peakThreshTop.sv */
`default_nettype none

module peakThreshTop #(
    parameter int pixelWidth = 8,
    parameter int binWidth   = 4,
    parameter int countWidth = 16
) (
    input  logic                                  clk,
    input  logic                                  res,
    input  logic                                  awvalid,
    output logic                                  awready,
    input  logic [peakThreshPkg::AXI_ADDR_W-1:0]  awaddr,
    input  logic                                  wvalid,
    output logic                                  wready,
    input  logic [peakThreshPkg::AXI_DATA_W-1:0]  wdata,
    output logic                                  bvalid,
    input  logic                                  bready,
    output logic [1:0]                            bresp,
    input  logic                                  arvalid,
    output logic                                  arready,
    input  logic [peakThreshPkg::AXI_ADDR_W-1:0]  araddr,
    output logic                                  rvalid,
    input  logic                                  rready,
    output logic [peakThreshPkg::AXI_DATA_W-1:0]  rdata,
    output logic [1:0]                            rresp
);

    logic                  pixWrite;
    logic [pixelWidth-1:0] pixData;
    logic                  histClear;
    logic                  searchStart;
    logic [binWidth-1:0]   binSel;
    logic [countWidth-1:0] binCount;
    logic                  busy;
    logic                  peakValid;
    logic [binWidth-1:0]   peakBin;
    logic [countWidth-1:0] peakCount;     // live from the scan
    logic [countWidth-1:0] peakCountReg;  // held with the thresholds
    logic [pixelWidth-1:0] thMinus;
    logic [pixelWidth-1:0] thPlus;
    logic                  resultValid;

    axiLiteRegs #(
        .pixelWidth(pixelWidth),
        .binWidth  (binWidth),
        .countWidth(countWidth)
    ) u_axiLiteRegs (
        .clk        (clk),
        .res        (res),
        .awvalid    (awvalid),
        .awready    (awready),
        .awaddr     (awaddr),
        .wvalid     (wvalid),
        .wready     (wready),
        .wdata      (wdata),
        .bvalid     (bvalid),
        .bready     (bready),
        .bresp      (bresp),
        .arvalid    (arvalid),
        .arready    (arready),
        .araddr     (araddr),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .rresp      (rresp),
        .busy       (busy),
        .resultValid(resultValid),
        .thMinus    (thMinus),
        .thPlus     (thPlus),
        .peakBin    (peakBin),
        .peakCount  (peakCountReg),
        .pixWrite   (pixWrite),
        .pixData    (pixData),
        .histClear  (histClear),
        .searchStart(searchStart)
    );

    histogramAccum #(
        .pixelWidth(pixelWidth),
        .binWidth  (binWidth),
        .countWidth(countWidth)
    ) u_histogramAccum (
        .clk      (clk),
        .res      (res),
        .pixWrite (pixWrite),
        .pixData  (pixData),
        .histClear(histClear),
        .binSel   (binSel),
        .binCount (binCount)
    );

    peakSearch #(
        .binWidth  (binWidth),
        .countWidth(countWidth)
    ) u_peakSearch (
        .clk        (clk),
        .res        (res),
        .searchStart(searchStart),
        .binCount   (binCount),
        .binSel     (binSel),
        .busy       (busy),
        .peakValid  (peakValid),
        .peakBin    (peakBin),
        .peakCount  (peakCount)
    );

    thresholdCalc #(
        .pixelWidth(pixelWidth),
        .binWidth  (binWidth),
        .countWidth(countWidth)
    ) u_thresholdCalc (
        .clk         (clk),
        .res         (res),
        .searchStart (searchStart),
        .peakValid   (peakValid),
        .peakBin     (peakBin),
        .peakCount   (peakCount),
        .thMinus     (thMinus),
        .thPlus      (thPlus),
        .peakCountOut(peakCountReg),
        .resultValid (resultValid)
    );

endmodule

`default_nettype wire

/* verif/peakThreshAssertions.sv */
`default_nettype none

module peakThreshAssertions (
    input logic clk,
    input logic res,
    input logic awvalid,
    input logic awready,
    input logic wready,
    input logic bvalid,
    input logic bready,
    input logic rvalid,
    input logic rready,
    input logic busy,
    input logic resultValid
);

    bHold: assert property (@(posedge clk) disable iff (!res)
        bvalid && !bready |=> bvalid)
        else $error("bvalid dropped before bready");

    rHold: assert property (@(posedge clk) disable iff (!res)
        rvalid && !rready |=> rvalid)
        else $error("rvalid dropped before rready");

    // done only once the scan is over
    busyDoneExcl: assert property (@(posedge clk) disable iff (!res)
        !(busy && resultValid))
        else $error("busy and resultValid high together");

    readyNeedsValid: assert property (@(posedge clk) disable iff (!res)
        (awready || wready) |-> awvalid)
        else $error("awready or wready high without awvalid");

endmodule

bind axiLiteRegs peakThreshAssertions u_peakThreshAssertions (
    .clk        (clk),
    .res        (res),
    .awvalid    (awvalid),
    .awready    (awready),
    .wready     (wready),
    .bvalid     (bvalid),
    .bready     (bready),
    .rvalid     (rvalid),
    .rready     (rready),
    .busy       (busy),
    .resultValid(resultValid)
);

`default_nettype wire

/* verif/peakThreshTb.sv */
`default_nettype none

module peakThreshTb;
    import peakThreshPkg::*;

    localparam int pixelWidth = 8;
    localparam int binWidth   = 4;
    localparam int countWidth = 16;
    localparam int binNum     = 2 ** binWidth;
    localparam int lowWidth   = pixelWidth - binWidth;
    localparam int countMax   = 2 ** countWidth - 1;

    // pixels written per test, sized for the watchdog
    localparam int pixRandom = 300;
    localparam int pixClamp  = 3 * 20;
    localparam int pixTie    = 20 + 8;
    localparam int pixStall  = 60;
    localparam int watchdogCycles = (pixRandom + pixClamp + pixTie + pixStall) * 20 + 2000;

    logic                  clk = 1'b0;
    logic                  res;
    logic                  awvalid;
    logic                  awready;
    logic [AXI_ADDR_W-1:0] awaddr;
    logic                  wvalid;
    logic                  wready;
    logic [AXI_DATA_W-1:0] wdata;
    logic                  bvalid;
    logic                  bready;
    logic [1:0]            bresp;
    logic                  arvalid;
    logic                  arready;
    logic [AXI_ADDR_W-1:0] araddr;
    logic                  rvalid;
    logic                  rready;
    logic [AXI_DATA_W-1:0] rdata;
    logic [1:0]            rresp;

    logic [31:0] lfsrState = 32'h22bf;
    int          refHist [binNum];

    // expected and observed responses, in issue order
    logic [31:0] qExpData [$];
    logic [31:0] qExpMask [$];
    logic [1:0]  qExpResp [$];
    logic        qIsWrite [$];
    string       qRegName [$];
    logic [31:0] qGotData [$];
    logic [1:0]  qGotResp [$];

    always #4 clk = ~clk;

    peakThreshTop #(
        .pixelWidth(pixelWidth),
        .binWidth  (binWidth),
        .countWidth(countWidth)
    ) u_peakThreshTop (
        .clk    (clk),
        .res    (res),
        .awvalid(awvalid),
        .awready(awready),
        .awaddr (awaddr),
        .wvalid (wvalid),
        .wready (wready),
        .wdata  (wdata),
        .bvalid (bvalid),
        .bready (bready),
        .bresp  (bresp),
        .arvalid(arvalid),
        .arready(arready),
        .araddr (araddr),
        .rvalid (rvalid),
        .rready (rready),
        .rdata  (rdata),
        .rresp  (rresp)
    );

    task automatic failRun();
        $display("Simulation FAILED");
        $fatal(1, "run stopped");
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrStep(lfsrState);
            v = {v[30:0], lfsrState[0]};  // one step per bit
        end
        return v;
    endfunction

    // lowest index wins a tie
    function automatic int refPeakBin();
        int best;
        best = 0;
        for (int b = 1; b < binNum; b++) begin
            if (refHist[b] > refHist[best]) begin
                best = b;
            end
        end
        return best;
    endfunction

    // returns {thPlus, thMinus}
    function automatic logic [15:0] refThresh(input int bin);
        int center;
        int sb;
        int pixMax;
        int lo;
        int hi;
        center = bin * (2 ** lowWidth) + 2 ** (lowWidth - 1);
        sb     = 2 ** (binWidth - 1) + 2 ** (binWidth - 2);
        pixMax = 2 ** pixelWidth - 1;
        if (center <= sb) begin
            lo = 0;
            hi = 2 * sb;
        end else if (center >= pixMax - sb) begin
            lo = pixMax - 2 * sb;
            hi = pixMax;
        end else begin
            lo = center - sb;
            hi = center + sb;
        end
        return {8'(hi), 8'(lo)};
    endfunction

    task automatic axiWrite(input logic [7:0] addr, input logic [31:0] data,
                            output logic [1:0] resp);
        int stall;
        stall = int'(randBits(3));
        @(posedge clk);
        awaddr  <= addr;
        awvalid <= 1'b1;
        wdata   <= data;
        wvalid  <= 1'b1;
        @(negedge clk);
        while (!awready) @(negedge clk);
        assert (wready) else begin
            $display("[ERROR] wready: expected 0x1, got 0x%0h", wready);
            failRun();
        end
        @(posedge clk);  // handshake edge
        awvalid <= 1'b0;
        wvalid  <= 1'b0;
        repeat (stall) @(posedge clk);
        bready <= 1'b1;
        @(negedge clk);
        while (!bvalid) @(negedge clk);
        resp = bresp;
        @(posedge clk);
        bready <= 1'b0;
    endtask

    task automatic axiRead(input logic [7:0] addr, output logic [31:0] data,
                           output logic [1:0] resp);
        int stall;
        stall = int'(randBits(3));
        @(posedge clk);
        araddr  <= addr;
        arvalid <= 1'b1;
        @(negedge clk);
        while (!arready) @(negedge clk);
        @(posedge clk);
        arvalid <= 1'b0;
        repeat (stall) @(posedge clk);  // hold off rready
        rready <= 1'b1;
        @(negedge clk);
        while (!rvalid) @(negedge clk);
        data = rdata;
        resp = rresp;
        @(posedge clk);
        rready <= 1'b0;
    endtask

    task automatic writeReg(input logic [7:0] addr, input logic [31:0] data,
                            input logic [1:0] expResp, input string name);
        logic [1:0] resp;
        qExpData.push_back(32'h0);
        qExpMask.push_back(32'h0);
        qExpResp.push_back(expResp);
        qIsWrite.push_back(1'b1);
        qRegName.push_back(name);
        axiWrite(addr, data, resp);
        qGotData.push_back(32'h0);
        qGotResp.push_back(resp);
    endtask

    task automatic readReg(input logic [7:0] addr, input logic [31:0] expData,
                           input logic [31:0] mask, input logic [1:0] expResp,
                           input string name, output logic [31:0] data);
        logic [1:0] resp;
        qExpData.push_back(expData);
        qExpMask.push_back(mask);
        qExpResp.push_back(expResp);
        qIsWrite.push_back(1'b0);
        qRegName.push_back(name);
        axiRead(addr, data, resp);
        qGotData.push_back(data);
        qGotResp.push_back(resp);
    endtask

    task automatic writePixel(input logic [pixelWidth-1:0] pix);
        int b;
        b = int'(pix[pixelWidth-1 -: binWidth]);
        if (refHist[b] < countMax) begin
            refHist[b]++;
        end
        writeReg(REG_PIXEL, 32'(pix), RESP_OKAY, "REG_PIXEL");
    endtask

    task automatic fillBin(input int bin, input int n);
        logic [pixelWidth-1:0] pix;
        for (int i = 0; i < n; i++) begin
            pix = {binWidth'(bin), lowWidth'(randBits(lowWidth))};
            writePixel(pix);
        end
    endtask

    task automatic randomPixels(input int n);
        for (int i = 0; i < n; i++) begin
            writePixel(pixelWidth'(randBits(pixelWidth)));
        end
    endtask

    task automatic clearHist();
        writeReg(REG_CTRL, 32'h1, RESP_OKAY, "REG_CTRL");
        for (int b = 0; b < binNum; b++) begin
            refHist[b] = 0;
        end
    endtask

    task automatic waitDone();
        logic [31:0] st;
        st = '0;
        while (!st[1]) begin
            readReg(REG_STATUS, 32'h0, 32'h0, RESP_OKAY, "REG_STATUS", st);
        end
    endtask

    task automatic searchAndCheck();
        int          pk;
        logic [15:0] th;
        logic [31:0] rd;
        pk = refPeakBin();
        th = refThresh(pk);
        writeReg(REG_CTRL, 32'h2, RESP_OKAY, "REG_CTRL");
        waitDone();
        readReg(REG_STATUS, 32'h2, '1, RESP_OKAY, "REG_STATUS", rd);  // done, idle
        readReg(REG_RESULT, (32'(pk) << 16) | 32'(th), '1, RESP_OKAY, "REG_RESULT", rd);
        readReg(REG_PEAKCNT, 32'(refHist[pk]), '1, RESP_OKAY, "REG_PEAKCNT", rd);
    endtask

    // responses are sampled on negedge and compared on a later posedge
    always @(posedge clk) begin : compareResp
        logic [31:0] eData;
        logic [31:0] eMask;
        logic [1:0]  eResp;
        logic        isWr;
        string       regName;
        logic [31:0] gData;
        logic [1:0]  gResp;
        while (qGotResp.size() > 0) begin
            eData   = qExpData.pop_front();
            eMask   = qExpMask.pop_front();
            eResp   = qExpResp.pop_front();
            isWr    = qIsWrite.pop_front();
            regName = qRegName.pop_front();
            gData   = qGotData.pop_front();
            gResp   = qGotResp.pop_front();
            assert ((gData & eMask) == (eData & eMask)) else begin
                $display("[ERROR] rdata at %s: expected 0x%08h, got 0x%08h",
                         regName, eData & eMask, gData & eMask);
                failRun();
            end
            assert (gResp == eResp) else begin
                $display("[ERROR] %s at %s: expected 0x%0h, got 0x%0h",
                         isWr ? "bresp" : "rresp", regName, eResp, gResp);
                failRun();
            end
        end
    end

    initial begin : watchdog
        repeat (watchdogCycles) @(posedge clk);
        $display("Timeout: the tests were still running after %0d cycles", watchdogCycles);
        failRun();
    end

    initial begin : stimulus
        logic [31:0] rd;
        res     <= 1'b0;
        awvalid <= 1'b0;
        awaddr  <= '0;
        wvalid  <= 1'b0;
        wdata   <= '0;
        bready  <= 1'b0;
        arvalid <= 1'b0;
        araddr  <= '0;
        rready  <= 1'b0;
        for (int b = 0; b < binNum; b++) begin
            refHist[b] = 0;
        end
        repeat (10) @(posedge clk);
        res <= 1'b1;
        @(posedge clk);

        // idle after reset, then a scan of the empty histogram
        readReg(REG_STATUS, 32'h0, '1, RESP_OKAY, "REG_STATUS", rd);
        searchAndCheck();

        randomPixels(pixRandom);
        searchAndCheck();

        // low clamp, high clamp, unclamped window
        clearHist();
        fillBin(0, 16);
        randomPixels(4);
        searchAndCheck();
        clearHist();
        fillBin(binNum - 1, 16);
        randomPixels(4);
        searchAndCheck();
        clearHist();
        fillBin(7, 16);
        randomPixels(4);
        searchAndCheck();

        // equal counts in bins 9 and 4
        clearHist();
        for (int i = 0; i < 10; i++) begin
            fillBin(9, 1);
            fillBin(4, 1);
        end
        searchAndCheck();
        clearHist();
        fillBin(11, 8);  // below the old tie counts, so stale bins would win
        searchAndCheck();

        writeReg(8'h20, 32'h5a, RESP_SLVERR, "unmapped 0x20");
        readReg(8'h24, 32'h0, '1, RESP_SLVERR, "unmapped 0x24", rd);
        readReg(8'h14, 32'h0, '1, RESP_SLVERR, "unmapped 0x14", rd);

        // final count shows every stalled pixel landed once
        clearHist();
        fillBin(6, pixStall);
        searchAndCheck();

        @(posedge clk);
        @(negedge clk);
        if (qExpResp.size() == 0 && qGotResp.size() == 0) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            $display("Some bus responses were never compared");
            failRun();
        end
    end

endmodule

`default_nettype wire

/* filelist.f */
verilog/peakThreshPkg.sv
verilog/axiLiteRegs.sv
verilog/histogramAccum.sv
verilog/peakSearch.sv
verilog/thresholdCalc.sv
verilog/peakThreshTop.sv
verif/peakThreshAssertions.sv
verif/peakThreshTb.sv

/* Makefile */
TOP := peakThreshTb

.PHONY: run lint clean

run:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f filelist.f
	./obj_dir/V$(TOP)

lint:
	verilator --lint-only -Wall --timing --assert --top-module $(TOP) -f filelist.f

clean:
	rm -rf obj_dir
